/* spart_drv_params.svh */
`ifndef SPART_DRV_PARAMS_SVH
`define SPART_DRV_PARAMS_SVH

//////////////////////////////////////////////////
// Widths
//////////////////////////////////////////////////

// SPART data byte
`define SPD_DB_W        8
// Register dump index, wraps at both ends
`define SPD_IDX_W       8
// Memory dump index
`define SPD_MIDX_W      5
// Low bits of the register index go to the target
`define SPD_REG_ADDR_W  5
// Target read data
`define SPD_DATA_W      32

// Number of entries shown per dump, both register and memory
`define SPD_DUMP_LIMIT  10

//////////////////////////////////////////////////
// Console characters
//////////////////////////////////////////////////

`define SPD_KEY_ENTER   8'h0d
// '1' steps down, '2' steps up
`define SPD_KEY_DEC     8'h31
`define SPD_KEY_INC     8'h32
`define SPD_ASCII_ZERO  8'h30
`define SPD_ASCII_SPACE 8'h20

// Baud divisor table, index is br_cfg
`define SPD_DIV_LO_0    8'hc0
`define SPD_DIV_LO_1    8'h80
`define SPD_DIV_LO_2    8'h00
`define SPD_DIV_LO_3    8'h00
`define SPD_DIV_HI_0    8'h12
`define SPD_DIV_HI_1    8'h25
`define SPD_DIV_HI_2    8'h4b
`define SPD_DIV_HI_3    8'h96

`endif

/* spart_drv_pkg.sv */
package spart_drv_pkg;

	//////////////////////////////////////////////////
	// Console FSM states
	//////////////////////////////////////////////////
	typedef enum logic [3:0] {
		// Divisor setup, one write each
		INIT_LO,
		INIT_HI,
		// Idle until a character arrives
		RX_WAIT,
		// Register dump, index digit then value digit
		SEND_IDX,
		SEND_REG,
		// Space after every dump entry
		SEND_SEP,
		// Memory dump digit
		SEND_MEM,
		// Space sent back for a step key
		ECHO
	} drv_state_e;

	// Decoded received character
	typedef enum logic [1:0] {
		CMD_NONE,
		CMD_DUMP,
		CMD_DEC,
		CMD_INC
	} cmd_e;

	// SPART register map seen on ioaddr
	typedef enum logic [1:0] {
		IO_TXRX   = 2'd0,
		IO_STATUS = 2'd1,
		IO_DB_LO  = 2'd2,
		IO_DB_HI  = 2'd3
	} io_reg_e;

endpackage

/* dump_ctl_if.sv */
`timescale 1ns/1ps
`include "spart_drv_params.svh"

interface dump_ctl_if;

	// Strobes from the FSM, one cycle each
	logic inc_idx;
	logic dec_idx;
	logic inc_midx;

	// Counter state back to the FSM
	logic [`SPD_IDX_W-1:0] reg_idx;
	logic reg_done;
	logic midx_zero;
	logic mem_done;

	modport fsm (
		output inc_idx,
		output dec_idx,
		output inc_midx,
		input  reg_idx,
		input  reg_done,
		input  midx_zero,
		input  mem_done
	);

	modport idx (
		input  inc_idx,
		input  dec_idx,
		input  inc_midx,
		output reg_idx,
		output reg_done,
		output midx_zero,
		output mem_done
	);

endinterface

/* dump_index.sv */
`timescale 1ns/1ps
`include "spart_drv_params.svh"

module dump_index (
	input  logic                    clk,
	input  logic                    rst,
	dump_ctl_if.idx                 ctl,
	output logic [`SPD_MIDX_W-1:0]  mem_addr
);

	logic [`SPD_IDX_W-1:0] reg_idx;
	logic [`SPD_MIDX_W-1:0] midx;

	//////////////////////////////////////////////////
	// Register index
	//////////////////////////////////////////////////

	// Stepped by the console keys and by the dump itself
	// Plain 8-bit arithmetic, so it wraps at 0 and 255
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			reg_idx <= '0;
		end else if (ctl.inc_idx) begin
			reg_idx <= reg_idx + `SPD_IDX_W'(1);
		end else if (ctl.dec_idx) begin
			reg_idx <= reg_idx - `SPD_IDX_W'(1);
		end
	end

	//////////////////////////////////////////////////
	// Memory index
	//////////////////////////////////////////////////

	// Only moves forward, one step per memory digit sent
	// Never cleared after reset, so a later dump skips memory
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			midx <= '0;
		end else if (ctl.inc_midx) begin
			midx <= midx + `SPD_MIDX_W'(1);
		end
	end

	//////////////////////////////////////////////////
	// Limit flags
	//////////////////////////////////////////////////

	// Flags follow the counters with no register stage
	always_comb begin
		ctl.reg_idx = reg_idx;
		// Register dump finished once the index reaches the limit
		ctl.reg_done = (reg_idx >= `SPD_IDX_W'(`SPD_DUMP_LIMIT));
		// Memory dump not started yet
		ctl.midx_zero = (midx == '0);
		ctl.mem_done = (midx >= `SPD_MIDX_W'(`SPD_DUMP_LIMIT));
	end

	// Memory index drives the target address directly
	assign mem_addr = midx;

endmodule

/* monitor_fsm.sv */
`timescale 1ns/1ps
`include "spart_drv_params.svh"

module monitor_fsm import spart_drv_pkg::*; (
	input  logic                    clk,
	input  logic                    rst,
	input  logic [1:0]              br_cfg,
	output logic                    iocs,
	output logic                    iorw,
	output io_reg_e                 ioaddr,
	output logic [`SPD_DB_W-1:0]    wdata,
	output logic                    wdata_en,
	input  logic [`SPD_DB_W-1:0]    rdata,
	input  logic                    rda,
	input  logic                    tbr,
	input  logic [`SPD_DATA_W-1:0]  reg_data,
	input  logic [`SPD_DATA_W-1:0]  mem_data,
	dump_ctl_if.fsm                 ctl
);

	drv_state_e state;
	drv_state_e state_nxt;
	cmd_e cmd;

	// Raw bus cycle request before the reset hold
	logic cs;
	logic rd;

	// Transmit request and its byte, shared by all send states
	logic tx;
	logic [`SPD_DB_W-1:0] tx_byte;

	logic [`SPD_DB_W-1:0] div_lo;
	logic [`SPD_DB_W-1:0] div_hi;
	logic [`SPD_DB_W-1:0] idx_digit;
	logic [`SPD_DB_W-1:0] reg_digit;
	logic [`SPD_DB_W-1:0] mem_digit;

	//////////////////////////////////////////////////
	// Baud divisor table
	//////////////////////////////////////////////////

	always_comb begin
		unique case (br_cfg)
			2'd0: begin
				div_lo = `SPD_DIV_LO_0;
				div_hi = `SPD_DIV_HI_0;
			end
			2'd1: begin
				div_lo = `SPD_DIV_LO_1;
				div_hi = `SPD_DIV_HI_1;
			end
			2'd2: begin
				div_lo = `SPD_DIV_LO_2;
				div_hi = `SPD_DIV_HI_2;
			end
			default: begin
				div_lo = `SPD_DIV_LO_3;
				div_hi = `SPD_DIV_HI_3;
			end
		endcase
	end

	// Single-digit ASCII from the low byte, larger values print as other characters
	assign idx_digit = ctl.reg_idx[`SPD_DB_W-1:0] + `SPD_ASCII_ZERO;
	assign reg_digit = reg_data[`SPD_DB_W-1:0] + `SPD_ASCII_ZERO;
	assign mem_digit = mem_data[`SPD_DB_W-1:0] + `SPD_ASCII_ZERO;

	// Received character decode
	always_comb begin
		unique case (rdata)
			`SPD_KEY_ENTER: cmd = CMD_DUMP;
			`SPD_KEY_DEC:   cmd = CMD_DEC;
			`SPD_KEY_INC:   cmd = CMD_INC;
			default:        cmd = CMD_NONE;
		endcase
	end

	// State register
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= INIT_LO;
		end else begin
			state <= state_nxt;
		end
	end

	//////////////////////////////////////////////////
	// Next state and bus cycle
	//////////////////////////////////////////////////

	always_comb begin
		// Default is an idle bus and hold in place
		state_nxt = state;
		cs = 1'b0;
		rd = 1'b1;
		ioaddr = IO_TXRX;
		wdata = '0;
		tx = 1'b0;
		tx_byte = `SPD_ASCII_SPACE;
		ctl.inc_idx = 1'b0;
		ctl.dec_idx = 1'b0;
		ctl.inc_midx = 1'b0;

		unique case (state)
			// Divisor writes need no handshake
			INIT_LO: begin
				cs = 1'b1;
				rd = 1'b0;
				ioaddr = IO_DB_LO;
				wdata = div_lo;
				state_nxt = INIT_HI;
			end
			INIT_HI: begin
				cs = 1'b1;
				rd = 1'b0;
				ioaddr = IO_DB_HI;
				wdata = div_hi;
				state_nxt = RX_WAIT;
			end
			RX_WAIT: begin
				// Read only when a character is waiting, decoded in the same cycle
				if (rda) begin
					cs = 1'b1;
					unique case (cmd)
						CMD_DUMP: state_nxt = SEND_IDX;
						CMD_DEC: begin
							ctl.dec_idx = 1'b1;
							state_nxt = ECHO;
						end
						CMD_INC: begin
							ctl.inc_idx = 1'b1;
							state_nxt = ECHO;
						end
						default: state_nxt = RX_WAIT;
					endcase
				end
			end
			SEND_IDX: begin
				// Registers done, fall through to memory without a bus cycle
				if (ctl.reg_done) begin
					state_nxt = SEND_MEM;
				end else if (tbr) begin
					tx = 1'b1;
					tx_byte = idx_digit;
					state_nxt = SEND_REG;
				end
			end
			SEND_REG: begin
				if (tbr) begin
					tx = 1'b1;
					tx_byte = reg_digit;
					ctl.inc_idx = 1'b1;
					state_nxt = SEND_SEP;
				end
			end
			SEND_SEP: begin
				// Memory index still zero means the register dump is running
				if (tbr) begin
					tx = 1'b1;
					state_nxt = ctl.midx_zero ? SEND_IDX : SEND_MEM;
				end
			end
			SEND_MEM: begin
				if (ctl.mem_done) begin
					state_nxt = RX_WAIT;
				end else if (tbr) begin
					tx = 1'b1;
					tx_byte = mem_digit;
					ctl.inc_midx = 1'b1;
					state_nxt = SEND_SEP;
				end
			end
			ECHO: begin
				if (tbr) begin
					tx = 1'b1;
					state_nxt = RX_WAIT;
				end
			end
			default: state_nxt = INIT_LO;
		endcase

		// Every transmit goes to the TX/RX register
		if (tx) begin
			cs = 1'b1;
			rd = 1'b0;
			wdata = tx_byte;
		end
	end

	// Bus stays idle while reset is held
	assign iocs = cs && !rst;
	assign iorw = rd;
	// Write data only driven on a real write cycle
	assign wdata_en = iocs && !rd;

endmodule

/* spart_drv_top.sv */
`timescale 1ns/1ps
`include "spart_drv_params.svh"

module spart_drv_top (
	input  logic                        clk,
	input  logic                        rst,
	input  logic [1:0]                  br_cfg,
	// SPART bus
	output logic                        iocs,
	output logic                        iorw,
	output logic [1:0]                  ioaddr,
	output logic [`SPD_DB_W-1:0]        wdata,
	output logic                        wdata_en,
	input  logic [`SPD_DB_W-1:0]        rdata,
	input  logic                        rda,
	input  logic                        tbr,
	// Debug target, answers combinationally
	output logic [`SPD_REG_ADDR_W-1:0]  reg_addr,
	input  logic [`SPD_DATA_W-1:0]      reg_data,
	output logic [`SPD_MIDX_W-1:0]      mem_addr,
	input  logic [`SPD_DATA_W-1:0]      mem_data
);

	dump_ctl_if ctl ();

	// Console FSM
	monitor_fsm u_fsm (
		.clk      (clk),
		.rst      (rst),
		.br_cfg   (br_cfg),
		.iocs     (iocs),
		.iorw     (iorw),
		.ioaddr   (ioaddr),
		.wdata    (wdata),
		.wdata_en (wdata_en),
		.rdata    (rdata),
		.rda      (rda),
		.tbr      (tbr),
		.reg_data (reg_data),
		.mem_data (mem_data),
		.ctl      (ctl.fsm)
	);

	// Dump counters
	dump_index u_idx (
		.clk      (clk),
		.rst      (rst),
		.ctl      (ctl.idx),
		.mem_addr (mem_addr)
	);

	// Register file address is the low part of the dump index
	assign reg_addr = ctl.reg_idx[`SPD_REG_ADDR_W-1:0];

endmodule

/* spart_drv_chk.sv */
`timescale 1ns/1ps
`include "spart_drv_params.svh"

module spart_drv_chk import spart_drv_pkg::*; (
	input logic                  clk,
	input logic                  rst,
	input logic [1:0]            br_cfg,
	input logic                  iocs,
	input logic                  iorw,
	input logic [1:0]            ioaddr,
	input logic [`SPD_DB_W-1:0]  wdata,
	input logic                  wdata_en,
	input logic                  rda,
	input logic                  tbr
);

	logic [`SPD_DB_W-1:0] div_lo_exp;
	logic [`SPD_DB_W-1:0] div_hi_exp;

	// Divisor bytes expected for the current br_cfg
	always_comb begin
		case (br_cfg)
			2'd0: {div_hi_exp, div_lo_exp} = {`SPD_DIV_HI_0, `SPD_DIV_LO_0};
			2'd1: {div_hi_exp, div_lo_exp} = {`SPD_DIV_HI_1, `SPD_DIV_LO_1};
			2'd2: {div_hi_exp, div_lo_exp} = {`SPD_DIV_HI_2, `SPD_DIV_LO_2};
			default: {div_hi_exp, div_lo_exp} = {`SPD_DIV_HI_3, `SPD_DIV_LO_3};
		endcase
	end

	//////////////////////////////////////////////////
	// Bus protocol
	//////////////////////////////////////////////////

	// Bus quiet while reset is held
	a_rst_idle: assert property (@(posedge clk) rst |-> (!iocs && !wdata_en))
		else $error("bus active during reset");

	// Low byte then high byte, right after reset release
	a_div_seq: assert property (@(posedge clk) $fell(rst) |->
		(iocs && !iorw && ioaddr == IO_DB_LO && wdata == div_lo_exp)
		##1 (iocs && !iorw && ioaddr == IO_DB_HI && wdata == div_hi_exp))
		else $error("divisor writes missing or wrong after reset");

	// Transmit only with buffer ready
	a_tx_tbr: assert property (@(posedge clk) disable iff (rst)
		(iocs && !iorw && ioaddr == IO_TXRX) |-> tbr)
		else $error("transmit write while tbr low");

	// Receive only with data available
	a_rx_rda: assert property (@(posedge clk) disable iff (rst) (iocs && iorw) |-> rda)
		else $error("receive read while rda low");

	a_wen: assert property (@(posedge clk) disable iff (rst) wdata_en == (iocs && !iorw))
		else $error("wdata_en does not match a write cycle");

endmodule

bind spart_drv_top spart_drv_chk u_chk (
	.clk      (clk),
	.rst      (rst),
	.br_cfg   (br_cfg),
	.iocs     (iocs),
	.iorw     (iorw),
	.ioaddr   (ioaddr),
	.wdata    (wdata),
	.wdata_en (wdata_en),
	.rda      (rda),
	.tbr      (tbr)
);

/* tb_spart_drv.sv */
`timescale 1ns/1ps
`include "spart_drv_params.svh"

module tb_spart_drv import spart_drv_pkg::*; ();

	localparam int TIMEOUT = 2000;

	logic clk;
	logic rst;
	logic [1:0] br_cfg;
	logic iocs;
	logic iorw;
	logic [1:0] ioaddr;
	logic [`SPD_DB_W-1:0] wdata;
	logic wdata_en;
	logic [`SPD_DB_W-1:0] rdata;
	logic rda;
	logic tbr = 1'b1;
	logic [`SPD_REG_ADDR_W-1:0] reg_addr;
	logic [`SPD_DATA_W-1:0] reg_data;
	logic [`SPD_MIDX_W-1:0] mem_addr;
	logic [`SPD_DATA_W-1:0] mem_data;

	// Shadow counters and the bytes still owed by the DUT
	logic [`SPD_IDX_W-1:0] sh_idx;
	logic [`SPD_MIDX_W-1:0] sh_midx;
	logic [`SPD_DB_W-1:0] exp_q[$];
	logic [`SPD_DB_W-1:0] exp_byte;
	logic stall_mode;
	int stretch = 0;

	spart_drv_top uut (.*);

	// Debug target model
	assign reg_data = {27'd0, reg_addr % 5'd7};
	assign mem_data = {27'd0, (mem_addr + 5'd2) % 5'd10};

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1, "run stopped at first error");
	endtask

	//////////////////////////////////////////////////
	// UART side
	//////////////////////////////////////////////////

	// Transmit buffer ready, random stretches high and low when stalling
	always @(negedge clk) begin
		if (!stall_mode) begin
			tbr <= 1'b1;
		end else if (stretch == 0) begin
			tbr <= ~tbr;
			stretch <= int'($urandom % 5);
		end else begin
			stretch <= stretch - 1;
		end
	end

	// Every TX/RX write checked against the shadow stream
	always @(posedge clk) begin
		if (!rst && iocs && !iorw && ioaddr == IO_TXRX) begin
			assert (exp_q.size() != 0) else
				abort_run($sformatf("unexpected byte %02h written at %0t", wdata, $time));
			if (exp_q.size() != 0) begin
				exp_byte = exp_q.pop_front();
				assert (wdata == exp_byte) else
					abort_run($sformatf("mismatch at %0t: wdata got %02h expected %02h",
						$time, wdata, exp_byte));
			end
		end
	end

	//////////////////////////////////////////////////
	// Shadow model
	//////////////////////////////////////////////////

	task automatic model_dump();
		logic [`SPD_REG_ADDR_W-1:0] ra;
		logic stop;
		stop = 1'b0;
		while (!stop && sh_idx < `SPD_IDX_W'(`SPD_DUMP_LIMIT)) begin
			ra = sh_idx[`SPD_REG_ADDR_W-1:0];
			exp_q.push_back(sh_idx + `SPD_ASCII_ZERO);
			exp_q.push_back({3'd0, ra % 5'd7} + `SPD_ASCII_ZERO);
			exp_q.push_back(`SPD_ASCII_SPACE);
			sh_idx = sh_idx + 8'd1;
			// Memory already moved, so the separator leads into memory
			if (sh_midx != 5'd0)
				stop = 1'b1;
		end
		while (sh_midx < `SPD_MIDX_W'(`SPD_DUMP_LIMIT)) begin
			exp_q.push_back({3'd0, (sh_midx + 5'd2) % 5'd10} + `SPD_ASCII_ZERO);
			exp_q.push_back(`SPD_ASCII_SPACE);
			sh_midx = sh_midx + 5'd1;
		end
	endtask

	task automatic model_key(input logic [`SPD_DB_W-1:0] c);
		if (c == `SPD_KEY_INC) begin
			sh_idx = sh_idx + 8'd1;
			exp_q.push_back(`SPD_ASCII_SPACE);
		end else if (c == `SPD_KEY_DEC) begin
			sh_idx = sh_idx - 8'd1;
			exp_q.push_back(`SPD_ASCII_SPACE);
		end else if (c == `SPD_KEY_ENTER) begin
			model_dump();
		end
	endtask

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////

	task automatic apply_reset(input logic [1:0] cfg);
		@(negedge clk);
		br_cfg = cfg;
		rst = 1'b1;
		repeat (8) @(negedge clk);
		rst = 1'b0;
		sh_idx = '0;
		sh_midx = '0;
		// Room for both divisor writes
		repeat (3) @(negedge clk);
	endtask

	// One character, rda held until the DUT reads it
	task automatic press(input logic [`SPD_DB_W-1:0] c);
		int n;
		logic seen;
		model_key(c);
		@(negedge clk);
		rdata = c;
		rda = 1'b1;
		seen = 1'b0;
		for (n = 0; n < TIMEOUT && !seen; n++) begin
			@(posedge clk);
			seen = iocs && iorw;
		end
		if (!seen)
			abort_run($sformatf("timeout: character %02h never read", c));
		@(negedge clk);
		rda = 1'b0;
	endtask

	// Until all owed bytes have gone out
	task automatic wait_drain();
		int n;
		for (n = 0; n < TIMEOUT && exp_q.size() != 0; n++)
			@(negedge clk);
		if (exp_q.size() != 0)
			abort_run($sformatf("timeout: %0d bytes never transmitted", exp_q.size()));
	endtask

	task automatic step_and_dump();
		repeat (3) press(`SPD_KEY_INC);
		press(`SPD_KEY_DEC);
		// Not a command, no echo
		press(8'h78);
		wait_drain();
		press(`SPD_KEY_ENTER);
		wait_drain();
	endtask

	initial begin
		void'($urandom(32'h28fe_1015));
		rst = 1'b1;
		br_cfg = 2'd0;
		rdata = '0;
		rda = 1'b0;
		stall_mode = 1'b0;
		sh_idx = '0;
		sh_midx = '0;

		apply_reset(2'd0);
		step_and_dump();

		// Same stream again under transmit back-pressure
		apply_reset(2'd3);
		stall_mode = 1'b1;
		step_and_dump();

		// Both counters at their limits after this
		press(`SPD_KEY_DEC);
		press(`SPD_KEY_ENTER);
		wait_drain();
		press(`SPD_KEY_ENTER);
		wait_drain();

		// Quiet window for stray bytes
		stall_mode = 1'b0;
		repeat (40) @(negedge clk);
		$display("Simulation passed");
		$finish;
	end

endmodule

/* flist.f */
+incdir+.
spart_drv_pkg.sv
dump_ctl_if.sv
dump_index.sv
monitor_fsm.sv
spart_drv_top.sv
spart_drv_chk.sv
tb_spart_drv.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_spart_drv
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(filter-out +incdir+%,$(shell cat $(FLIST))) spart_drv_params.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^Simulation passed$$" $(LOG) || (echo "FAIL: see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
